// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module mipsPipelineTb -o simv
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi
./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation returned status $status"
fi
exit $status

// ==== sim.f ====
verilog/cpuPkg.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/fetchStage.sv
verilog/executeStage.sv
verilog/writebackStage.sv
verilog/mipsPipeline.sv
sim/mipsPipelineTb.sv

// ==== sim/mipsPipelineTb.sv ====
`timescale 1ns/1ps

module mipsPipelineTb;
   import cpuPkg::*;

   // Six tests, each a reset plus at most 64 instructions at up to
   // 3 cycles apiece with stalls, plus drain and margin
   localparam int CYCLE_LIMIT = 3000;
   localparam int DRAIN_CYCLES = 20;
   // Enough model steps to reach the self-loop of every program
   localparam int MODEL_STEPS = 400;

   logic clk;
   logic reset;
   logic stall;
   wordT instruction;
   wordT dmemRdata;
   wordT imemAddr;
   wordT dmemAddr;
   wordT dmemWdata;
   logic dmemWe;

   // Memory models, word index from address bits 11:2
   wordT imem [1024];
   wordT dmem [1024];

   wordT prog [$];
   wordT expAddr [$];
   wordT expData [$];
   wordT actAddr [$];
   wordT actData [$];

   wordT rngState;
   wordT opA;
   wordT opB;
   logic [15:0] immR;
   logic [4:0] shAmt;
   logic [15:0] storeOff;
   logic collecting;
   logic stallOn;
   logic stallNext;
   int cycles;

   mipsPipeline dut0 (
      .clk         (clk),
      .reset       (reset),
      .stall       (stall),
      .instruction (instruction),
      .dmemRdata   (dmemRdata),
      .imemAddr    (imemAddr),
      .dmemAddr    (dmemAddr),
      .dmemWdata   (dmemWdata),
      .dmemWe      (dmemWe)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Global run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run exceeded %0d cycles, the DUT stopped making progress", CYCLE_LIMIT);
         $display("Test failures found");
         $fatal(1, "timeout");
      end
   end

   // Synchronous-read memories and store monitor
   always @(posedge clk) begin
      instruction <= imem[imemAddr[11:2]];
      dmemRdata   <= dmem[dmemAddr[11:2]];
      if (dmemWe) begin
         dmem[dmemAddr[11:2]] <= dmemWdata;
      end
      if (collecting && dmemWe) begin
         actAddr.push_back(dmemAddr);
         actData.push_back(dmemWdata);
      end
      // No store may leak out while frozen
      if (stall) begin
         checkWe("dmemWe", dmemWe, 1'b0);
      end
   end

   // Random stall, about one cycle in four
   always @(posedge clk) begin
      if (stallOn) begin
         rngState = xorshift(rngState);
         stallNext = (rngState[4:3] == 2'b00);
      end else begin
         stallNext = 1'b0;
      end
      #1;
      stall = stallNext;
   end

   function automatic wordT xorshift(input wordT x);
      wordT v;
      v = x ^ (x << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   task automatic nextRandom(output wordT v);
      rngState = xorshift(rngState);
      v = rngState;
   endtask

   // Data memory contents before each test
   function automatic wordT fillWord(input int idx);
      wordT a;
      a = wordT'(idx << 2);
      return {a[15:0] ^ 16'hC3A5, a[15:0]};
   endfunction

   // Instruction encoders
   function automatic wordT rType(input functT fn, input regAddrT rs, input regAddrT rt,
                                  input regAddrT rd, input logic [4:0] sh);
      return {OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic wordT iType(input opcodeT op, input regAddrT rs, input regAddrT rt,
                                  input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic wordT jType(input opcodeT op, input wordT target);
      return {op, target[27:2]};
   endfunction

   // Byte address of program slot idx
   function automatic wordT at(input int idx);
      return RESET_VECTOR + wordT'(idx << 2);
   endfunction

   task automatic emit(input wordT w);
      prog.push_back(w);
   endtask

   // Jump to itself, nop in the delay slot
   task automatic endLoop();
      emit(jType(OP_J, at(prog.size())));
      emit(32'h0000_0000);
   endtask

   // Result goes to r3, then stored to the next slot
   task automatic storeResult(input wordT ins);
      emit(ins);
      emit(iType(OP_SW, 5'd0, 5'd3, storeOff));
      storeOff = storeOff + 16'd4;
   endtask

   task automatic checkWord(input string name, input wordT got, input wordT want);
      if (got !== want) begin
         $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, want);
         $display("Test failures found");
         $fatal(1, "word check");
      end
   endtask

   task automatic checkWe(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
         $display("Test failures found");
         $fatal(1, "enable check");
      end
   endtask

   task automatic checkResetOutputs();
      checkWe("dmemWe", dmemWe, 1'b0);
      checkWord("imemAddr", imemAddr, RESET_VECTOR);
   endtask

   // Instruction-level model with one delay slot
   task automatic runModel();
      wordT r [32];
      wordT m [1024];
      wordT pc, npc, nnpc, ins, addr, immS, immZ;
      regAddrT rs, rt, rd;
      int idx;
      expAddr.delete();
      expData.delete();
      for (int i = 0; i < 32; i++) begin
         r[i] = '0;
      end
      for (int i = 0; i < 1024; i++) begin
         m[i] = fillWord(i);
      end
      pc = RESET_VECTOR;
      npc = RESET_VECTOR + 32'd4;
      for (int s = 0; s < MODEL_STEPS; s++) begin
         idx = int'((pc - RESET_VECTOR) >> 2);
         ins = (idx < prog.size()) ? prog[idx] : '0;
         rs = ins[25:21];
         rt = ins[20:16];
         rd = ins[15:11];
         immS = {{16{ins[15]}}, ins[15:0]};
         immZ = {16'h0000, ins[15:0]};
         addr = r[rs] + immS;
         nnpc = npc + 32'd4;
         case (ins[31:26])
            OP_RTYPE: begin
               case (ins[5:0])
                  FN_SLL:  r[rd] = r[rt] << ins[10:6];
                  FN_SRL:  r[rd] = r[rt] >> ins[10:6];
                  FN_JR:   nnpc = r[rs];
                  FN_ADDU: r[rd] = r[rs] + r[rt];
                  FN_SUBU: r[rd] = r[rs] - r[rt];
                  FN_AND:  r[rd] = r[rs] & r[rt];
                  FN_OR:   r[rd] = r[rs] | r[rt];
                  FN_XOR:  r[rd] = r[rs] ^ r[rt];
                  FN_SLT:  r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
                  FN_SLTU: r[rd] = (r[rs] < r[rt]) ? 32'd1 : 32'd0;
                  default: ;
               endcase
            end
            OP_ADDIU: r[rt] = r[rs] + immS;
            OP_ANDI:  r[rt] = r[rs] & immZ;
            OP_ORI:   r[rt] = r[rs] | immZ;
            OP_LUI:   r[rt] = {ins[15:0], 16'h0000};
            OP_LW:    r[rt] = m[addr[11:2]];
            OP_SW: begin
               m[addr[11:2]] = r[rt];
               expAddr.push_back(addr);
               expData.push_back(r[rt]);
            end
            // Branch targets count from the delay slot
            OP_BEQ: if (r[rs] == r[rt]) nnpc = npc + {immS[29:0], 2'b00};
            OP_BNE: if (r[rs] != r[rt]) nnpc = npc + {immS[29:0], 2'b00};
            OP_J:   nnpc = {npc[31:28], ins[25:0], 2'b00};
            OP_JAL: begin
               r[31] = pc + 32'd8;
               nnpc = {npc[31:28], ins[25:0], 2'b00};
            end
            default: ;
         endcase
         r[0] = '0;
         pc = npc;
         npc = nnpc;
      end
   endtask

   task automatic loadMemories();
      for (int i = 0; i < 1024; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : '0;
         dmem[i] = fillWord(i);
      end
   endtask

   // Reset, run the loaded program and compare its stores with the model
   task automatic runProgram(input logic withStall);
      int waited;
      waited = 0;
      runModel();
      @(posedge clk);
      #1;
      reset = 1'b1;
      stallOn = 1'b0;
      collecting = 1'b0;
      loadMemories();
      repeat (4) begin
         @(negedge clk);
         checkResetOutputs();
         @(posedge clk);
      end
      #1;
      reset = 1'b0;
      // First cycle out of reset still fetches the reset vector
      @(negedge clk);
      checkResetOutputs();
      actAddr.delete();
      actData.delete();
      collecting = 1'b1;
      stallOn = withStall;
      while (actAddr.size() < expAddr.size() && waited < 4 * prog.size() + 40) begin
         @(posedge clk);
         waited++;
      end
      // Catch stray stores after the last expected one
      repeat (DRAIN_CYCLES) @(posedge clk);
      if (actAddr.size() != expAddr.size()) begin
         $display("Store count wrong, the DUT made %0d stores and %0d were expected",
                  actAddr.size(), expAddr.size());
         $display("Test failures found");
         $fatal(1, "store count");
      end
      for (int i = 0; i < expAddr.size(); i++) begin
         checkWord($sformatf("dmemAddr[%0d]", i), actAddr[i], expAddr[i]);
         checkWord($sformatf("dmemWdata[%0d]", i), actData[i], expData[i]);
      end
      stallOn = 1'b0;
      collecting = 1'b0;
   endtask

   // Operands in r1 and r2, every operation stored from r3
   task automatic buildAluProgram();
      prog.delete();
      storeOff = 16'h0100;
      emit(iType(OP_LUI, 5'd0, 5'd1, opA[31:16]));
      emit(iType(OP_ORI, 5'd1, 5'd1, opA[15:0]));
      emit(iType(OP_LUI, 5'd0, 5'd2, opB[31:16]));
      emit(iType(OP_ORI, 5'd2, 5'd2, opB[15:0]));
      storeResult(rType(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
      storeResult(rType(FN_SUBU, 5'd1, 5'd2, 5'd3, 5'd0));
      storeResult(rType(FN_AND, 5'd1, 5'd2, 5'd3, 5'd0));
      storeResult(rType(FN_OR, 5'd1, 5'd2, 5'd3, 5'd0));
      storeResult(rType(FN_XOR, 5'd1, 5'd2, 5'd3, 5'd0));
      // Signs differ, so signed and unsigned compares disagree
      storeResult(rType(FN_SLT, 5'd1, 5'd2, 5'd3, 5'd0));
      storeResult(rType(FN_SLTU, 5'd1, 5'd2, 5'd3, 5'd0));
      storeResult(rType(FN_SLT, 5'd2, 5'd1, 5'd3, 5'd0));
      storeResult(rType(FN_SLTU, 5'd2, 5'd1, 5'd3, 5'd0));
      storeResult(rType(FN_SLL, 5'd0, 5'd1, 5'd3, shAmt));
      storeResult(rType(FN_SRL, 5'd0, 5'd1, 5'd3, shAmt));
      storeResult(iType(OP_ADDIU, 5'd1, 5'd3, immR));
      storeResult(iType(OP_ANDI, 5'd1, 5'd3, immR));
      storeResult(iType(OP_ORI, 5'd1, 5'd3, immR));
      storeResult(iType(OP_LUI, 5'd0, 5'd3, immR));
      endLoop();
   endtask

   task automatic testAlu();
      wordT v;
      nextRandom(v);
      opA = v | 32'h8000_0000;
      nextRandom(v);
      opB = v & 32'h7FFF_FFFF;
      nextRandom(v);
      immR = v[15:0];
      shAmt = v[20:16];
      buildAluProgram();
      runProgram(1'b0);
   endtask

   task automatic testForwarding();
      prog.delete();
      emit(iType(OP_ORI, 5'd0, 5'd1, 16'h1234));
      emit(rType(FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
      emit(rType(FN_SUBU, 5'd2, 5'd1, 5'd3, 5'd0));
      emit(rType(FN_XOR, 5'd3, 5'd2, 5'd4, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd4, 16'h0100));
      // r0 written, must still read zero
      emit(iType(OP_ADDIU, 5'd4, 5'd0, 16'h0005));
      emit(rType(FN_ADDU, 5'd0, 5'd4, 5'd5, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd5, 16'h0104));
      emit(iType(OP_SW, 5'd0, 5'd0, 16'h0108));
      emit(rType(FN_OR, 5'd5, 5'd3, 5'd6, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd6, 16'h010C));
      emit(iType(OP_LUI, 5'd0, 5'd7, 16'hFEDC));
      emit(iType(OP_ORI, 5'd7, 5'd7, 16'hBA98));
      emit(rType(FN_SLTU, 5'd6, 5'd7, 5'd8, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd8, 16'h0110));
      // Store base forwarded
      emit(iType(OP_ADDIU, 5'd0, 5'd9, 16'h0200));
      emit(iType(OP_SW, 5'd9, 5'd7, 16'h0000));
      emit(rType(FN_SUBU, 5'd7, 5'd6, 5'd10, 5'd0));
      emit(rType(FN_AND, 5'd10, 5'd7, 5'd10, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd10, 16'h0114));
      endLoop();
      runProgram(1'b0);
   endtask

   task automatic testMemory();
      prog.delete();
      emit(iType(OP_ORI, 5'd0, 5'd1, 16'hBEEF));
      emit(iType(OP_LUI, 5'd0, 5'd2, 16'h1357));
      emit(rType(FN_OR, 5'd2, 5'd1, 5'd2, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd2, 16'h0120));
      emit(iType(OP_SW, 5'd0, 5'd1, 16'h0124));
      // Load used by the next instruction
      emit(iType(OP_LW, 5'd0, 5'd3, 16'h0120));
      emit(rType(FN_ADDU, 5'd3, 5'd3, 5'd4, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd4, 16'h0128));
      emit(iType(OP_LW, 5'd0, 5'd5, 16'h0124));
      emit(iType(OP_SW, 5'd0, 5'd5, 16'h012C));
      // Untouched word holds the fill pattern
      emit(iType(OP_LW, 5'd0, 5'd6, 16'h0300));
      emit(rType(FN_XOR, 5'd6, 5'd2, 5'd7, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd7, 16'h0130));
      emit(iType(OP_ADDIU, 5'd0, 5'd10, 16'h0140));
      emit(iType(OP_LW, 5'd10, 5'd11, 16'hFFFC));
      emit(iType(OP_SW, 5'd10, 5'd11, 16'h0004));
      endLoop();
      runProgram(1'b0);
   endtask

   task automatic testControlFlow();
      prog.delete();
      emit(iType(OP_ORI, 5'd0, 5'd1, 16'h0005));
      emit(iType(OP_ORI, 5'd0, 5'd2, 16'h0005));
      // Taken beq, slot 4 skipped
      emit(iType(OP_BEQ, 5'd1, 5'd2, 16'h0002));
      emit(iType(OP_ADDIU, 5'd0, 5'd3, 16'h0001));
      emit(iType(OP_ADDIU, 5'd0, 5'd3, 16'h0063));
      emit(iType(OP_SW, 5'd0, 5'd3, 16'h0100));
      // Not-taken bne falls through
      emit(iType(OP_BNE, 5'd1, 5'd2, 16'h0002));
      emit(iType(OP_ADDIU, 5'd0, 5'd4, 16'h0007));
      emit(iType(OP_ADDIU, 5'd4, 5'd4, 16'h0001));
      emit(iType(OP_SW, 5'd0, 5'd4, 16'h0104));
      // Taken bne, store in the delay slot
      emit(iType(OP_BNE, 5'd1, 5'd0, 16'h0002));
      emit(iType(OP_SW, 5'd0, 5'd1, 16'h0108));
      emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'h0066));
      emit(jType(OP_J, at(16)));
      emit(iType(OP_ADDIU, 5'd0, 5'd5, 16'h0003));
      emit(iType(OP_ADDIU, 5'd0, 5'd5, 16'h004D));
      emit(iType(OP_SW, 5'd0, 5'd5, 16'h010C));
      // Backward loop, three passes
      emit(iType(OP_ADDIU, 5'd0, 5'd7, 16'h0003));
      emit(iType(OP_ADDIU, 5'd7, 5'd7, 16'hFFFF));
      emit(iType(OP_BNE, 5'd7, 5'd0, 16'hFFFE));
      emit(iType(OP_SW, 5'd0, 5'd7, 16'h011C));
      // Call, link stored from the delay slot
      emit(jType(OP_JAL, at(26)));
      emit(iType(OP_SW, 5'd0, 5'd31, 16'h0110));
      emit(iType(OP_SW, 5'd0, 5'd6, 16'h0118));
      endLoop();
      // Subroutine at slot 26
      emit(iType(OP_ADDIU, 5'd0, 5'd6, 16'h0055));
      emit(rType(FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
      emit(iType(OP_SW, 5'd0, 5'd6, 16'h0114));
      runProgram(1'b0);
   endtask

   // ALU program again, frozen on random cycles
   task automatic testStall();
      buildAluProgram();
      runProgram(1'b1);
   endtask

   // Store at the reset vector sits in fetch for the whole reset window
   task automatic testReset();
      prog.delete();
      emit(iType(OP_SW, 5'd0, 5'd0, 16'h0100));
      endLoop();
      runProgram(1'b0);
   endtask

   initial begin
      reset = 1'b1;
      stall = 1'b0;
      instruction = '0;
      dmemRdata = '0;
      cycles = 0;
      collecting = 1'b0;
      stallOn = 1'b0;
      stallNext = 1'b0;
      rngState = 32'd65;
      storeOff = 16'h0100;
      for (int i = 0; i < 1024; i++) begin
         imem[i] = '0;
         dmem[i] = fillWord(i);
      end
      testAlu();
      testForwarding();
      testMemory();
      testControlFlow();
      testStall();
      testReset();
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
   input  cpuPkg::wordT  a,
   input  cpuPkg::wordT  b,
   input  cpuPkg::aluOpT aluOp,
   output cpuPkg::wordT  result
);
   import cpuPkg::*;

   always_comb begin
      case (aluOp)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         // Signed compare
         ALU_SLT:  result = {{(WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
         ALU_SLTU: result = {{(WORD_W-1){1'b0}}, a < b};
         // Shift amount comes in on a
         ALU_SLL:  result = b << a[4:0];
         ALU_SRL:  result = b >> a[4:0];
         ALU_LUI:  result = {b[15:0], 16'h0000};
         default:  result = '0;
      endcase
   end

endmodule

// ==== verilog/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
   input  cpuPkg::opcodeT opcode,
   input  cpuPkg::functT  funct,
   output logic           regWrite,
   output logic           regDst,
   output logic           aluSrc,
   output logic           shift,
   output logic           zeroExt,
   output logic           memToReg,
   output logic           memWrite,
   output logic           branchEq,
   output logic           branchNe,
   output logic           jump,
   output logic           jumpLink,
   output logic           jumpReg,
   output cpuPkg::aluOpT  aluOp
);
   import cpuPkg::*;

   always_comb begin
      // Default is a no-op, nothing written
      regWrite = 1'b0;
      regDst   = 1'b0;
      aluSrc   = 1'b0;
      shift    = 1'b0;
      zeroExt  = 1'b0;
      memToReg = 1'b0;
      memWrite = 1'b0;
      branchEq = 1'b0;
      branchNe = 1'b0;
      jump     = 1'b0;
      jumpLink = 1'b0;
      jumpReg  = 1'b0;
      aluOp    = ALU_ADD;
      case (opcode)
         OP_RTYPE: begin
            regWrite = 1'b1;
            regDst   = 1'b1;
            case (funct)
               FN_SLL:  begin shift = 1'b1; aluOp = ALU_SLL; end
               FN_SRL:  begin shift = 1'b1; aluOp = ALU_SRL; end
               // jr only redirects, no result
               FN_JR:   begin regWrite = 1'b0; jumpReg = 1'b1; end
               FN_ADDU: aluOp = ALU_ADD;
               FN_SUBU: aluOp = ALU_SUB;
               FN_AND:  aluOp = ALU_AND;
               FN_OR:   aluOp = ALU_OR;
               FN_XOR:  aluOp = ALU_XOR;
               FN_SLT:  aluOp = ALU_SLT;
               FN_SLTU: aluOp = ALU_SLTU;
               default: regWrite = 1'b0;
            endcase
         end
         OP_ADDIU: begin regWrite = 1'b1; aluSrc = 1'b1; end
         OP_ANDI:  begin regWrite = 1'b1; aluSrc = 1'b1; zeroExt = 1'b1; aluOp = ALU_AND; end
         OP_ORI:   begin regWrite = 1'b1; aluSrc = 1'b1; zeroExt = 1'b1; aluOp = ALU_OR; end
         OP_LUI:   begin regWrite = 1'b1; aluSrc = 1'b1; aluOp = ALU_LUI; end
         // Address is base plus signed offset
         OP_LW:    begin regWrite = 1'b1; aluSrc = 1'b1; memToReg = 1'b1; end
         OP_SW:    begin aluSrc = 1'b1; memWrite = 1'b1; end
         OP_BEQ:   branchEq = 1'b1;
         OP_BNE:   branchNe = 1'b1;
         OP_J:     jump = 1'b1;
         OP_JAL:   begin jump = 1'b1; jumpLink = 1'b1; regWrite = 1'b1; end
         default:  aluOp = ALU_ADD;
      endcase
   end

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

   // Datapath and register index widths
   localparam int WORD_W = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [WORD_W-1:0] wordT;
   typedef logic [REG_ADDR_W-1:0] regAddrT;

   // First fetch address out of reset
   localparam wordT RESET_VECTOR = 32'h4000_0000;
   // Return-address register for jal
   localparam regAddrT LINK_REG = 5'd31;

   // Primary opcodes, bits 31:26
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_JAL   = 6'h03,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_LUI   = 6'h0f,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcodeT;

   // R-type function codes, bits 5:0
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_JR   = 6'h08,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } functT;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
   } aluOpT;

endpackage

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
   input  logic            clk,
   input  logic            reset,
   input  logic            stall,
   input  cpuPkg::wordT    pcF,
   input  cpuPkg::regAddrT rsF,
   input  cpuPkg::regAddrT rtF,
   input  cpuPkg::regAddrT rdF,
   input  logic [4:0]      shamtF,
   input  logic [25:0]     targetF,
   input  cpuPkg::wordT    immF,
   input  logic            regWriteF,
   input  logic            regDstF,
   input  logic            aluSrcF,
   input  logic            shiftF,
   input  logic            memToRegF,
   input  logic            memWriteF,
   input  logic            branchEqF,
   input  logic            branchNeF,
   input  logic            jumpF,
   input  logic            jumpLinkF,
   input  logic            jumpRegF,
   input  cpuPkg::aluOpT   aluOpF,
   input  cpuPkg::wordT    rd1F,
   input  cpuPkg::wordT    rd2F,
   input  cpuPkg::wordT    writeBack,
   input  cpuPkg::regAddrT waM,
   input  logic            regWriteM,
   output cpuPkg::wordT    nextPc,
   output cpuPkg::wordT    imemAddr,
   output cpuPkg::wordT    aluOutE,
   output cpuPkg::wordT    dmemWdata,
   output cpuPkg::wordT    pcE,
   output logic            dmemWe,
   output logic            regWriteE,
   output logic            regDstE,
   output logic            memToRegE,
   output logic            jumpLinkE,
   output cpuPkg::regAddrT rtE,
   output cpuPkg::regAddrT rdE
);
   import cpuPkg::*;

   logic        resetDly;
   logic        aluSrcE, shiftE, memWriteE;
   logic        branchEqE, branchNeE, jumpE, jumpRegE;
   regAddrT     rsE;
   logic [4:0]  shamtE;
   logic [25:0] targetE;
   wordT        immE, rd1E, rd2E, nextPcE;
   aluOpT       aluOpE;
   wordT        rsFwd, rtFwd, aluA, aluB;
   logic        fwdA, fwdB, branchTaken;

   // Fetch of the first cycle after reset repeats the reset vector
   always_ff @(posedge clk) begin
      resetDly <= reset;
   end

   // Control bits, a bubble out of reset
   always_ff @(posedge clk) begin
      if (reset || resetDly) begin
         regWriteE <= 1'b0;
         regDstE   <= 1'b0;
         aluSrcE   <= 1'b0;
         shiftE    <= 1'b0;
         memToRegE <= 1'b0;
         memWriteE <= 1'b0;
         branchEqE <= 1'b0;
         branchNeE <= 1'b0;
         jumpE     <= 1'b0;
         jumpLinkE <= 1'b0;
         jumpRegE  <= 1'b0;
      end else if (!stall) begin
         regWriteE <= regWriteF;
         regDstE   <= regDstF;
         aluSrcE   <= aluSrcF;
         shiftE    <= shiftF;
         memToRegE <= memToRegF;
         memWriteE <= memWriteF;
         branchEqE <= branchEqF;
         branchNeE <= branchNeF;
         jumpE     <= jumpF;
         jumpLinkE <= jumpLinkF;
         jumpRegE  <= jumpRegF;
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      if (!stall) begin
         pcE     <= pcF;
         rsE     <= rsF;
         rtE     <= rtF;
         rdE     <= rdF;
         shamtE  <= shamtF;
         targetE <= targetF;
         immE    <= immF;
         rd1E    <= rd1F;
         rd2E    <= rd2F;
         aluOpE  <= aluOpF;
      end
   end

   // Last fetch address, replayed while stalled
   always_ff @(posedge clk) begin
      if (reset) begin
         nextPcE <= RESET_VECTOR;
      end else if (!stall) begin
         nextPcE <= nextPc;
      end
   end

   // Memory/writeback result bypass, load data included
   assign fwdA  = regWriteM && waM != '0 && waM == rsE;
   assign fwdB  = regWriteM && waM != '0 && waM == rtE;
   assign rsFwd = fwdA ? writeBack : rd1E;
   assign rtFwd = fwdB ? writeBack : rd2E;

   assign aluA = shiftE ? {{(WORD_W-5){1'b0}}, shamtE} : rsFwd;
   assign aluB = aluSrcE ? immE : rtFwd;

   alu alu0 (
      .a      (aluA),
      .b      (aluB),
      .aluOp  (aluOpE),
      .result (aluOutE)
   );

   assign branchTaken = (branchEqE && rsFwd == rtFwd) || (branchNeE && rsFwd != rtFwd);

   // pcF is the delay slot, so every target is relative to it
   always_comb begin
      if (reset || resetDly) begin
         nextPc = RESET_VECTOR;
      end else if (branchTaken) begin
         nextPc = pcF + {immE[WORD_W-3:0], 2'b00};
      end else if (jumpE) begin
         nextPc = {pcF[31:28], targetE, 2'b00};
      end else if (jumpRegE) begin
         nextPc = rsFwd;
      end else begin
         nextPc = pcF + 32'd4;
      end
   end

   assign imemAddr  = stall ? nextPcE : nextPc;
   // One write per store, never while frozen
   assign dmemWe    = memWriteE && !stall;
   assign dmemWdata = rtFwd;

endmodule

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
   input  logic            clk,
   input  logic            reset,
   input  logic            stall,
   input  cpuPkg::wordT    nextPc,
   input  cpuPkg::wordT    instruction,
   output cpuPkg::wordT    pcF,
   output cpuPkg::opcodeT  opcodeF,
   output cpuPkg::functT   functF,
   output cpuPkg::regAddrT rsF,
   output cpuPkg::regAddrT rtF,
   output cpuPkg::regAddrT rdF,
   output logic [4:0]      shamtF,
   output logic [25:0]     targetF,
   output cpuPkg::wordT    immF,
   output logic            regWriteF,
   output logic            regDstF,
   output logic            aluSrcF,
   output logic            shiftF,
   output logic            zeroExtF,
   output logic            memToRegF,
   output logic            memWriteF,
   output logic            branchEqF,
   output logic            branchNeF,
   output logic            jumpF,
   output logic            jumpLinkF,
   output logic            jumpRegF,
   output cpuPkg::aluOpT   aluOpF
);
   import cpuPkg::*;

   // PC tracks the address the instruction memory sampled
   always_ff @(posedge clk) begin
      if (reset) begin
         pcF <= RESET_VECTOR;
      end else if (!stall) begin
         pcF <= nextPc;
      end
   end

   // Field split
   assign opcodeF = opcodeT'(instruction[31:26]);
   assign functF  = functT'(instruction[5:0]);
   assign rsF     = instruction[25:21];
   assign rtF     = instruction[20:16];
   assign rdF     = instruction[15:11];
   assign shamtF  = instruction[10:6];
   assign targetF = instruction[25:0];

   // Logical immediates zero-extend, the rest sign-extend
   assign immF = zeroExtF ? {16'h0000, instruction[15:0]}
                          : {{16{instruction[15]}}, instruction[15:0]};

   controlDecoder decoder0 (
      .opcode   (opcodeF),
      .funct    (functF),
      .regWrite (regWriteF),
      .regDst   (regDstF),
      .aluSrc   (aluSrcF),
      .shift    (shiftF),
      .zeroExt  (zeroExtF),
      .memToReg (memToRegF),
      .memWrite (memWriteF),
      .branchEq (branchEqF),
      .branchNe (branchNeF),
      .jump     (jumpF),
      .jumpLink (jumpLinkF),
      .jumpReg  (jumpRegF),
      .aluOp    (aluOpF)
   );

endmodule

// ==== verilog/mipsPipeline.sv ====
`timescale 1ns/1ps

module mipsPipeline (
   input  logic         clk,
   input  logic         reset,
   input  logic         stall,
   input  cpuPkg::wordT instruction,
   input  cpuPkg::wordT dmemRdata,
   output cpuPkg::wordT imemAddr,
   output cpuPkg::wordT dmemAddr,
   output cpuPkg::wordT dmemWdata,
   output logic         dmemWe
);
   import cpuPkg::*;

   // Fetch outputs
   wordT        pcF, immF, rd1F, rd2F;
   regAddrT     rsF, rtF, rdF;
   logic [4:0]  shamtF;
   logic [25:0] targetF;
   logic        regWriteF, regDstF, aluSrcF, shiftF, memToRegF, memWriteF;
   logic        branchEqF, branchNeF, jumpF, jumpLinkF, jumpRegF;
   aluOpT       aluOpF;
   // Execute outputs
   wordT        nextPc, aluOutE, pcE;
   regAddrT     rtE, rdE;
   logic        regWriteE, regDstE, memToRegE, jumpLinkE;
   // Writeback outputs
   wordT        writeBack, regWd;
   regAddrT     waM, regWa;
   logic        regWriteM;

   fetchStage fetch0 (
      .clk(clk), .reset(reset), .stall(stall), .nextPc(nextPc),
      .instruction(instruction), .pcF(pcF), .opcodeF(), .functF(),
      .rsF(rsF), .rtF(rtF), .rdF(rdF), .shamtF(shamtF), .targetF(targetF),
      .immF(immF), .regWriteF(regWriteF), .regDstF(regDstF), .aluSrcF(aluSrcF),
      .shiftF(shiftF), .zeroExtF(), .memToRegF(memToRegF),
      .memWriteF(memWriteF), .branchEqF(branchEqF), .branchNeF(branchNeF),
      .jumpF(jumpF), .jumpLinkF(jumpLinkF), .jumpRegF(jumpRegF), .aluOpF(aluOpF)
   );

   regFile regs0 (
      .clk(clk), .reset(reset), .stall(stall), .ra1(rsF), .ra2(rtF),
      .wa(regWa), .we(regWriteM), .wd(regWd), .rd1(rd1F), .rd2(rd2F)
   );

   executeStage execute0 (
      .clk(clk), .reset(reset), .stall(stall), .pcF(pcF), .rsF(rsF), .rtF(rtF),
      .rdF(rdF), .shamtF(shamtF), .targetF(targetF), .immF(immF),
      .regWriteF(regWriteF), .regDstF(regDstF), .aluSrcF(aluSrcF), .shiftF(shiftF),
      .memToRegF(memToRegF), .memWriteF(memWriteF), .branchEqF(branchEqF),
      .branchNeF(branchNeF), .jumpF(jumpF), .jumpLinkF(jumpLinkF),
      .jumpRegF(jumpRegF), .aluOpF(aluOpF), .rd1F(rd1F), .rd2F(rd2F),
      .writeBack(writeBack), .waM(waM), .regWriteM(regWriteM), .nextPc(nextPc),
      .imemAddr(imemAddr), .aluOutE(aluOutE), .dmemWdata(dmemWdata), .pcE(pcE),
      .dmemWe(dmemWe), .regWriteE(regWriteE), .regDstE(regDstE),
      .memToRegE(memToRegE), .jumpLinkE(jumpLinkE), .rtE(rtE), .rdE(rdE)
   );

   writebackStage writeback0 (
      .clk(clk), .reset(reset), .stall(stall), .aluOutE(aluOutE), .pcE(pcE),
      .dmemRdata(dmemRdata), .rtE(rtE), .rdE(rdE), .regWriteE(regWriteE),
      .regDstE(regDstE), .memToRegE(memToRegE), .jumpLinkE(jumpLinkE),
      .dmemAddr(dmemAddr), .writeBack(writeBack), .regWd(regWd), .waM(waM),
      .regWa(regWa), .regWriteM(regWriteM)
   );

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic            clk,
   input  logic            reset,
   input  logic            stall,
   input  cpuPkg::regAddrT ra1,
   input  cpuPkg::regAddrT ra2,
   input  cpuPkg::regAddrT wa,
   input  logic            we,
   input  cpuPkg::wordT    wd,
   output cpuPkg::wordT    rd1,
   output cpuPkg::wordT    rd2
);
   import cpuPkg::*;

   wordT regs [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && !stall && wa != '0) begin
         regs[wa] <= wd;
      end
   end

   // Register 0 reads zero, same-cycle write passes straight through
   assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== verilog/writebackStage.sv ====
`timescale 1ns/1ps

module writebackStage (
   input  logic            clk,
   input  logic            reset,
   input  logic            stall,
   input  cpuPkg::wordT    aluOutE,
   input  cpuPkg::wordT    pcE,
   input  cpuPkg::wordT    dmemRdata,
   input  cpuPkg::regAddrT rtE,
   input  cpuPkg::regAddrT rdE,
   input  logic            regWriteE,
   input  logic            regDstE,
   input  logic            memToRegE,
   input  logic            jumpLinkE,
   output cpuPkg::wordT    dmemAddr,
   output cpuPkg::wordT    writeBack,
   output cpuPkg::wordT    regWd,
   output cpuPkg::regAddrT waM,
   output cpuPkg::regAddrT regWa,
   output logic            regWriteM
);
   import cpuPkg::*;

   logic    regDstM, memToRegM, jumpLinkM;
   wordT    aluOutM, pcM;
   regAddrT rtM, rdM;

   always_ff @(posedge clk) begin
      if (reset) begin
         regWriteM <= 1'b0;
         regDstM   <= 1'b0;
         memToRegM <= 1'b0;
         jumpLinkM <= 1'b0;
      end else if (!stall) begin
         regWriteM <= regWriteE;
         regDstM   <= regDstE;
         memToRegM <= memToRegE;
         jumpLinkM <= jumpLinkE;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         aluOutM <= aluOutE;
         pcM     <= pcE;
         rtM     <= rtE;
         rdM     <= rdE;
      end
   end

   // Keep the load address steady so its data stays on dmemRdata
   assign dmemAddr = stall ? aluOutM : aluOutE;

   // jal writes PC+8 to the link register, visible to the bypass too
   assign waM       = jumpLinkM ? LINK_REG : (regDstM ? rdM : rtM);
   assign writeBack = jumpLinkM ? pcM + 32'd8 : (memToRegM ? dmemRdata : aluOutM);

   // Register file write port
   assign regWa = waM;
   assign regWd = writeBack;

endmodule
